//--- native_soc_defines.svh
`ifndef NATIVE_SOC_DEFINES_SVH
`define NATIVE_SOC_DEFINES_SVH

////////////////////
// bus geometry
////////////////////
`define NS_ADDR_W 32
`define NS_DATA_W 32
// byte lanes per word
`define NS_STRB_W 4

////////////////////
// slave memories
////////////////////
`define NS_N_SLAVES 4
// word address per bank, 1024 words
`define NS_BANK_ADDR_W 10

////////////////////
// reset control
////////////////////
// access here sets mem_sel and steps the soft reset
`define NS_CTRL_ADDR 32'hffff_fffc
// internal reset releases once the top bit sets
`define NS_POR_CNT_W 11
// length of the one-hot soft reset rotation
`define NS_SOFT_RST_W 5

`endif

//--- native_soc_pkg.sv
`default_nettype none

`include "native_soc_defines.svh"

package native_soc_pkg;

   ////////////////////
   // bus fields
   ////////////////////
   // byte address from the master
   typedef logic [`NS_ADDR_W-1:0] bus_addr_t;
   // one data word
   typedef logic [`NS_DATA_W-1:0] bus_data_t;
   // byte write enables, all zero for a read
   typedef logic [`NS_STRB_W-1:0] bus_strb_t;

   ////////////////////
   // decode fields
   ////////////////////
   // bank number, taken from the top address bits
   typedef logic [$clog2(`NS_N_SLAVES)-1:0] slave_idx_t;
   // word address inside one bank
   typedef logic [`NS_BANK_ADDR_W-1:0] bank_addr_t;

   ////////////////////
   // reset state
   ////////////////////
   typedef logic [`NS_POR_CNT_W-1:0] por_cnt_t;
   typedef logic [`NS_SOFT_RST_W-1:0] soft_rst_t;

endpackage

`default_nettype wire

//--- reset_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "native_soc_defines.svh"

module reset_ctrl
   import native_soc_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      m_valid,
   input  bus_addr_t m_addr,
   output logic      resetn_int,
   output logic      mem_sel,
   output logic      cpu_resetn
);

   // rotation start value with only the top bit set
   localparam soft_rst_t SOFT_RST_INIT = {1'b1, {(`NS_SOFT_RST_W-1){1'b0}}};

   por_cnt_t  por_cnt;
   soft_rst_t soft_rst;
   logic      ctrl_hit;

   ////////////////////
   // power-on reset
   ////////////////////
   // counts up from the fall of reset
   // stops once the top bit sets 1024 edges later
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         por_cnt <= '0;
      end else if (!por_cnt[`NS_POR_CNT_W-1]) begin
         por_cnt <= por_cnt + por_cnt_t'(1);
      end
   end

   // internal reset released by the counter top bit
   assign resetn_int = por_cnt[`NS_POR_CNT_W-1];

   ////////////////////
   // soft reset
   ////////////////////
   // master is touching the control word
   assign ctrl_hit = m_valid && (m_addr == `NS_CTRL_ADDR);

   // held in start state until the system leaves reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         mem_sel  <= 1'b0;
         soft_rst <= SOFT_RST_INIT;
      end else if (!resetn_int) begin
         mem_sel  <= 1'b0;
         soft_rst <= SOFT_RST_INIT;
      end else if (ctrl_hit) begin
         // boot region remap is sticky
         mem_sel  <= 1'b1;
         // one place per cycle of held access
         // bit 0 reached after four edges
         soft_rst <= {soft_rst[0], soft_rst[`NS_SOFT_RST_W-1:1]};
      end else begin
         // rotation restarts once the access drops
         soft_rst <= SOFT_RST_INIT;
      end
   end

   ////////////////////
   // core reset
   ////////////////////
   // low during internal reset or while bit 0 is set
   assign cpu_resetn = resetn_int && !soft_rst[0];

endmodule

`default_nettype wire

//--- native_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "native_soc_defines.svh"

module native_decoder
   import native_soc_pkg::*;
(
   input  logic                    m_valid,
   input  bus_addr_t               m_addr,
   input  logic                    mem_sel,
   output slave_idx_t              slave_sel,
   output logic [`NS_N_SLAVES-1:0] bank_valid,
   output bank_addr_t              bank_addr
);

   // width of the region field at the top of the address
   localparam int IDX_W = $bits(slave_idx_t);

   slave_idx_t raw_idx;

   ////////////////////
   // region decode
   ////////////////////
   // top address bits pick the bank
   assign raw_idx = m_addr[`NS_ADDR_W-1 -: IDX_W];

   // after the control access the boot region
   // is served by bank 1 instead of bank 0
   always_comb begin
      if (mem_sel && (raw_idx == '0)) begin
         slave_sel = slave_idx_t'(1);
      end else begin
         slave_sel = raw_idx;
      end
   end

   ////////////////////
   // bank strobes
   ////////////////////
   // one-hot, nothing raised without a valid access
   always_comb begin
      bank_valid = '0;
      if (m_valid) begin
         bank_valid[slave_sel] = 1'b1;
      end
   end

   // word address, byte offset dropped
   assign bank_addr = m_addr[`NS_BANK_ADDR_W+1:2];

endmodule

`default_nettype wire

//--- mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bank
   import native_soc_pkg::*;
#(
   parameter int ADDR_W = 10
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              valid,
   input  logic [ADDR_W-1:0] addr,
   input  bus_data_t         wdata,
   input  bus_strb_t         wstrb,
   output bus_data_t         rdata,
   output logic              ready
);

   // bits per strobe lane
   localparam int BYTE_W = $bits(bus_data_t) / $bits(bus_strb_t);
   localparam int DEPTH  = 2 ** ADDR_W;

   bus_data_t mem [DEPTH];

   ////////////////////
   // word storage
   ////////////////////
   // byte-lane writes, only enabled lanes change
   // read word registered on every valid access
   always_ff @(posedge clk) begin
      if (valid) begin
         for (int i = 0; i < $bits(bus_strb_t); i++) begin
            if (wstrb[i]) begin
               mem[addr][i*BYTE_W +: BYTE_W] <= wdata[i*BYTE_W +: BYTE_W];
            end
         end
         rdata <= mem[addr];
      end
   end

   ////////////////////
   // handshake
   ////////////////////
   // fixed one-cycle answer, no wait states
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready <= 1'b0;
      end else begin
         ready <= valid;
      end
   end

endmodule

`default_nettype wire

//--- resp_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "native_soc_defines.svh"

module resp_mux
   import native_soc_pkg::*;
(
   input  slave_idx_t              slave_sel,
   input  bus_data_t               bank_rdata [`NS_N_SLAVES],
   input  logic [`NS_N_SLAVES-1:0] bank_ready,
   output bus_data_t               m_rdata,
   output logic                    m_ready
);

   ////////////////////
   // response select
   ////////////////////
   // address is held until ready, so the
   // live decode still points at the answering bank
   always_comb begin
      m_rdata = '0;
      m_ready = 1'b0;
      for (int k = 0; k < `NS_N_SLAVES; k++) begin
         if (slave_sel == slave_idx_t'(k)) begin
            m_rdata = bank_rdata[k];
            m_ready = bank_ready[k];
         end
      end
   end

endmodule

`default_nettype wire

//--- native_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "native_soc_defines.svh"

module native_soc_top
   import native_soc_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       m_valid,
   input  bus_addr_t  m_addr,
   input  bus_data_t  m_wdata,
   input  bus_strb_t  m_wstrb,
   output bus_data_t  m_rdata,
   output logic       m_ready,
   output logic       resetn_int_sys,
   output logic       cpu_resetn,
   output logic       sys_mem_sel,
   output slave_idx_t s_sel
);

   // reset state
   logic resetn_int;
   logic mem_sel;
   logic bank_reset;

   // decode results
   slave_idx_t              slave_sel;
   logic [`NS_N_SLAVES-1:0] bank_valid;
   bank_addr_t              bank_addr;

   // per-bank responses
   bus_data_t               bank_rdata [`NS_N_SLAVES];
   logic [`NS_N_SLAVES-1:0] bank_ready;

   ////////////////////
   // reset control
   ////////////////////
   reset_ctrl u_reset_ctrl (
      .clk        (clk),
      .reset      (reset),
      .m_valid    (m_valid),
      .m_addr     (m_addr),
      .resetn_int (resetn_int),
      .mem_sel    (mem_sel),
      .cpu_resetn (cpu_resetn)
   );

   // banks held until the power-on count expires
   assign bank_reset = ~resetn_int;

   ////////////////////
   // address decode
   ////////////////////
   native_decoder u_decoder (
      .m_valid    (m_valid),
      .m_addr     (m_addr),
      .mem_sel    (mem_sel),
      .slave_sel  (slave_sel),
      .bank_valid (bank_valid),
      .bank_addr  (bank_addr)
   );

   ////////////////////
   // slave memories
   ////////////////////
   // write data and strobes shared, valid per bank
   // bank 3 also answers the control word
   for (genvar k = 0; k < `NS_N_SLAVES; k++) begin : gen_bank
      mem_bank #(
         .ADDR_W (`NS_BANK_ADDR_W)
      ) u_bank (
         .clk   (clk),
         .reset (bank_reset),
         .valid (bank_valid[k]),
         .addr  (bank_addr),
         .wdata (m_wdata),
         .wstrb (m_wstrb),
         .rdata (bank_rdata[k]),
         .ready (bank_ready[k])
      );
   end

   ////////////////////
   // response path
   ////////////////////
   resp_mux u_resp_mux (
      .slave_sel  (slave_sel),
      .bank_rdata (bank_rdata),
      .bank_ready (bank_ready),
      .m_rdata    (m_rdata),
      .m_ready    (m_ready)
   );

   // status seen from outside
   assign resetn_int_sys = resetn_int;
   assign sys_mem_sel    = mem_sel;
   assign s_sel          = slave_sel;

endmodule

`default_nettype wire

//--- tb_native_soc.sv
`timescale 1ns/1ps
`default_nettype none

`include "native_soc_defines.svh"

module tb_native_soc
   import native_soc_pkg::*;
;

   localparam int BYTE_W        = `NS_DATA_W / `NS_STRB_W;
   localparam int WORDS         = 2 ** `NS_BANK_ADDR_W;
   // writes per bank in the random test
   localparam int N_WR          = 8;
   localparam int POR_EDGES     = 1024;
   localparam int POR_TIMEOUT   = 2000;
   localparam int READY_TIMEOUT = 16;
   // cycles the control access is held
   localparam int HOLD          = 5;

   logic       clk = 1'b0;
   logic       reset;
   logic       m_valid;
   bus_addr_t  m_addr;
   bus_data_t  m_wdata;
   bus_strb_t  m_wstrb;
   bus_data_t  m_rdata;
   logic       m_ready;
   logic       resetn_int_sys;
   logic       cpu_resetn;
   logic       sys_mem_sel;
   slave_idx_t s_sel;

   // expected contents per bank, plus the offsets written in test 2
   bus_data_t  model [`NS_N_SLAVES][WORDS];
   bank_addr_t wr_off [`NS_N_SLAVES][N_WR];

   integer seed;
   int     errors;
   int     tests_ok;
   int     tests_bad;

   native_soc_top dut0 (
      .clk            (clk),
      .reset          (reset),
      .m_valid        (m_valid),
      .m_addr         (m_addr),
      .m_wdata        (m_wdata),
      .m_wstrb        (m_wstrb),
      .m_rdata        (m_rdata),
      .m_ready        (m_ready),
      .resetn_int_sys (resetn_int_sys),
      .cpu_resetn     (cpu_resetn),
      .sys_mem_sel    (sys_mem_sel),
      .s_sel          (s_sel)
   );

   // 20 ns period
   always #10 clk = ~clk;

   ////////////////////
   // helpers
   ////////////////////
   task automatic show_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
   endtask

   // region in bits 31:30, word offset in bits 11:2
   function automatic bus_addr_t make_addr(input int region, input bank_addr_t off);
      bus_addr_t a;
      a = '0;
      a[`NS_ADDR_W-1:`NS_ADDR_W-2] = slave_idx_t'(region);
      a[`NS_BANK_ADDR_W+1:2] = off;
      return a;
   endfunction

   // enabled bytes take the new value
   function automatic bus_data_t merge_bytes(input bus_data_t old_w, input bus_data_t new_w,
                                             input bus_strb_t strb);
      bus_data_t r;
      r = old_w;
      for (int b = 0; b < `NS_STRB_W; b++) begin
         if (strb[b]) begin
            r[b*BYTE_W +: BYTE_W] = new_w[b*BYTE_W +: BYTE_W];
         end
      end
      return r;
   endfunction

   task automatic report_test(input string name, input int err0);
      if (errors == err0) begin
         tests_ok++;
         $display("test %s: ok", name);
      end else begin
         tests_bad++;
         $display("test %s: %0d errors", name, errors - err0);
      end
   endtask

   // one access, ready expected one cycle after valid
   task automatic bus_access(input bus_addr_t addr, input bus_data_t wdata,
                             input bus_strb_t wstrb, output bus_data_t rdata,
                             output slave_idx_t sel);
      int lat;
      lat   = 0;
      rdata = '0;
      sel   = '0;
      @(posedge clk);
      m_valid <= 1'b1;
      m_addr  <= addr;
      m_wdata <= wdata;
      m_wstrb <= wstrb;
      @(negedge clk);
      if (m_ready !== 1'b0) begin
         show_mismatch("m_ready", 32'(m_ready), 32'd0);
      end
      while (m_ready !== 1'b1 && lat < READY_TIMEOUT) begin
         @(posedge clk);
         lat++;
         @(negedge clk);
      end
      if (m_ready !== 1'b1) begin
         $display("timeout %0t no m_ready for access to %h", $time, addr);
         errors++;
      end else begin
         if (lat != 1) begin
            show_mismatch("ready latency", lat, 32'd1);
         end
         rdata = m_rdata;
         sel   = s_sel;
      end
      // master drops valid once ready is seen
      @(posedge clk);
      m_valid <= 1'b0;
      m_wstrb <= '0;
   endtask

   ////////////////////
   // tests
   ////////////////////
   task automatic test_power_on();
      int err0;
      int edges;
      int early;
      err0  = errors;
      edges = 0;
      early = 0;
      @(negedge clk);
      if (resetn_int_sys !== 1'b0) begin
         show_mismatch("resetn_int_sys", 32'(resetn_int_sys), 32'd0);
      end
      if (cpu_resetn !== 1'b0) begin
         show_mismatch("cpu_resetn", 32'(cpu_resetn), 32'd0);
      end
      if (sys_mem_sel !== 1'b0) begin
         show_mismatch("sys_mem_sel", 32'(sys_mem_sel), 32'd0);
      end
      // count edges until internal reset releases
      while (resetn_int_sys !== 1'b1 && edges < POR_TIMEOUT) begin
         @(posedge clk);
         edges++;
         @(negedge clk);
         if (resetn_int_sys !== 1'b1 && cpu_resetn !== 1'b0) begin
            early++;
         end
      end
      if (resetn_int_sys !== 1'b1) begin
         $display("timeout %0t resetn_int_sys never rose", $time);
         errors++;
      end else begin
         if (edges != POR_EDGES) begin
            show_mismatch("power-on edges", edges, POR_EDGES);
         end
         if (cpu_resetn !== 1'b1) begin
            show_mismatch("cpu_resetn", 32'(cpu_resetn), 32'd1);
         end
      end
      if (early != 0) begin
         $display("cpu_resetn left reset before the internal reset released");
         errors++;
      end
      report_test("1 power-on reset", err0);
   endtask

   task automatic test_random_banks();
      int         err0;
      bank_addr_t off;
      bus_data_t  data;
      bus_data_t  rd;
      slave_idx_t sel;
      err0 = errors;
      for (int b = 1; b < `NS_N_SLAVES; b++) begin
         for (int i = 0; i < N_WR; i++) begin
            off  = bank_addr_t'($random(seed));
            data = $random(seed);
            wr_off[b][i] = off;
            bus_access(make_addr(b, off), data, 4'hf, rd, sel);
            if (sel !== slave_idx_t'(b)) begin
               show_mismatch("s_sel", 32'(sel), b);
            end
            model[b][off] = data;
         end
      end
      // read everything back
      for (int b = 1; b < `NS_N_SLAVES; b++) begin
         for (int i = 0; i < N_WR; i++) begin
            off = wr_off[b][i];
            bus_access(make_addr(b, off), '0, 4'h0, rd, sel);
            if (sel !== slave_idx_t'(b)) begin
               show_mismatch("s_sel", 32'(sel), b);
            end
            if (rd !== model[b][off]) begin
               show_mismatch("m_rdata", rd, model[b][off]);
            end
         end
      end
      report_test("2 random words", err0);
   endtask

   task automatic test_byte_strobes();
      int         err0;
      int         region;
      bank_addr_t off;
      bus_data_t  data;
      bus_data_t  rd;
      bus_strb_t  strb;
      slave_idx_t sel;
      err0 = errors;
      // every partial strobe pattern, banks 2 and 3
      for (int s = 1; s < 15; s++) begin
         strb   = bus_strb_t'(s);
         region = 2 + (s % 2);
         off    = bank_addr_t'($random(seed));
         data   = $random(seed);
         bus_access(make_addr(region, off), data, 4'hf, rd, sel);
         model[region][off] = data;
         data = $random(seed);
         bus_access(make_addr(region, off), data, strb, rd, sel);
         model[region][off] = merge_bytes(model[region][off], data, strb);
         bus_access(make_addr(region, off), '0, 4'h0, rd, sel);
         if (rd !== model[region][off]) begin
            show_mismatch("m_rdata", rd, model[region][off]);
         end
      end
      report_test("3 byte strobes", err0);
   endtask

   task automatic test_soft_reset();
      int         err0;
      int         low_cnt;
      bank_addr_t off;
      bus_data_t  data;
      bus_data_t  rd;
      slave_idx_t sel;
      err0    = errors;
      low_cnt = 0;
      if (sys_mem_sel !== 1'b0) begin
         show_mismatch("sys_mem_sel", 32'(sys_mem_sel), 32'd0);
      end
      // boot region still on bank 0
      off  = bank_addr_t'($random(seed));
      data = $random(seed);
      bus_access(make_addr(0, off), data, 4'hf, rd, sel);
      if (sel !== slave_idx_t'(0)) begin
         show_mismatch("s_sel", 32'(sel), 32'd0);
      end
      model[0][off] = data;
      bus_access(make_addr(0, off), '0, 4'h0, rd, sel);
      if (rd !== model[0][off]) begin
         show_mismatch("m_rdata", rd, model[0][off]);
      end
      // control word held long enough for the pulse
      @(posedge clk);
      m_valid <= 1'b1;
      m_addr  <= `NS_CTRL_ADDR;
      m_wdata <= '0;
      m_wstrb <= '0;
      @(negedge clk);
      if (cpu_resetn !== 1'b1) begin
         show_mismatch("cpu_resetn", 32'(cpu_resetn), 32'd1);
      end
      for (int i = 1; i <= HOLD + 2; i++) begin
         @(posedge clk);
         if (i == HOLD) begin
            m_valid <= 1'b0;
         end
         @(negedge clk);
         if (cpu_resetn !== 1'b1) begin
            low_cnt++;
         end
      end
      if (low_cnt != 1) begin
         show_mismatch("cpu_resetn low cycles", low_cnt, 32'd1);
      end
      if (sys_mem_sel !== 1'b1) begin
         show_mismatch("sys_mem_sel", 32'(sys_mem_sel), 32'd1);
      end
      report_test("4 soft reset", err0);
   endtask

   task automatic test_boot_remap();
      int         err0;
      bank_addr_t off;
      bus_data_t  rd;
      slave_idx_t sel;
      err0 = errors;
      // region 0 now reads the bank 1 words
      for (int i = 0; i < N_WR; i++) begin
         off = wr_off[1][i];
         bus_access(make_addr(0, off), '0, 4'h0, rd, sel);
         if (sel !== slave_idx_t'(1)) begin
            show_mismatch("s_sel", 32'(sel), 32'd1);
         end
         if (rd !== model[1][off]) begin
            show_mismatch("m_rdata", rd, model[1][off]);
         end
      end
      if (sys_mem_sel !== 1'b1) begin
         show_mismatch("sys_mem_sel", 32'(sys_mem_sel), 32'd1);
      end
      report_test("5 boot remap", err0);
   endtask

   ////////////////////
   // main sequence
   ////////////////////
   initial begin
      seed      = 82;
      errors    = 0;
      tests_ok  = 0;
      tests_bad = 0;
      reset   <= 1'b1;
      m_valid <= 1'b0;
      m_addr  <= '0;
      m_wdata <= '0;
      m_wstrb <= '0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      // order matters, test 5 relies on test 4
      test_power_on();
      test_random_banks();
      test_byte_strobes();
      test_soft_reset();
      test_boot_remap();
      $display("tests ok %0d, tests with errors %0d, errors %0d", tests_ok, tests_bad, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- native_soc.f
+incdir+.
native_soc_pkg.sv
reset_ctrl.sv
native_decoder.sv
mem_bank.sv
resp_mux.sv
native_soc_top.sv
tb_native_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the native bus memory testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

top=tb_native_soc
obj=obj_dir
log=sim.log

# compile the file list into a binary
verilator --binary --timing --timescale 1ns/1ps \
   -f native_soc.f --top-module "$top" -Mdir "$obj"
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

# run, keeping the output for the result search
"./$obj/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qF '*** PASSED ***' "$log"; then
   echo "result: pass"
   exit 0
fi

echo "result: fail, see $log"
exit 1
